// File: files.f
+incdir+verif
rtl/lbm_pkg.sv
rtl/moment_if.sv
rtl/relax_if.sv
rtl/lbm_moments.sv
rtl/lbm_axis_relax.sv
rtl/lbm_diag_relax.sv
rtl/lbm_rest_combine.sv
rtl/lbm_collide.sv
verif/lbm_collide_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the collision stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module lbm_collide_tb \
	-o lbm_collide_sim > build.log 2>&1 \
	&& ./obj_dir/lbm_collide_sim > sim.log 2>&1 \
	|| echo "Build or simulation returned an error, see build.log and sim.log"

grep -q "Finished with no errors" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/lbm_ref.svh
`ifndef LBM_REF_SVH
`define LBM_REF_SVH

// Expected outputs of one site
typedef struct packed {
	lbm_pkg::pop_t   pop;
	lbm_pkg::fixed_t ux;
	lbm_pkg::fixed_t uy;
} site_result_t;

// BGK step for one direction
function automatic lbm_pkg::fixed_t bgk_relax(lbm_pkg::fixed_t n, lbm_pkg::fixed_t w_rho,
		lbm_pkg::fixed_t bracket, lbm_pkg::fixed_t omega);
	lbm_pkg::fixed_t eq;
	eq = lbm_pkg::fx_mul(w_rho, bracket);
	return n + lbm_pkg::fx_mul(omega, eq - n);
endfunction

function automatic site_result_t lbm_ref_collide(lbm_pkg::pop_t p, lbm_pkg::fixed_t omega);
	site_result_t    res;
	lbm_pkg::fixed_t rho;
	lbm_pkg::fixed_t dev;
	lbm_pkg::fixed_t inv;
	lbm_pkg::fixed_t ux2;
	lbm_pkg::fixed_t uy2;
	lbm_pkg::fixed_t uxuy;
	lbm_pkg::fixed_t usq;
	lbm_pkg::fixed_t base;
	lbm_pkg::fixed_t w9;
	lbm_pkg::fixed_t w36;
	lbm_pkg::fixed_t cx;
	lbm_pkg::fixed_t cy;
	lbm_pkg::fixed_t dp;
	lbm_pkg::fixed_t dm;

	rho = p.n0 + p.nn + p.ns + p.ne + p.nw + p.nne + p.nnw + p.nse + p.nsw;
	dev = rho - lbm_pkg::FX_ONE;
	inv = lbm_pkg::FX_ONE - dev + lbm_pkg::fx_mul(dev, dev);

	res.ux = lbm_pkg::fx_mul(inv, (p.ne + p.nne + p.nse) - (p.nw + p.nnw + p.nsw));
	res.uy = lbm_pkg::fx_mul(inv, (p.nn + p.nne + p.nnw) - (p.ns + p.nse + p.nsw));

	ux2  = lbm_pkg::fx_mul(res.ux, res.ux);
	uy2  = lbm_pkg::fx_mul(res.uy, res.uy);
	uxuy = lbm_pkg::fx_mul(res.ux, res.uy);
	usq  = ux2 + uy2;
	// Common part of every bracket, 1 - 1.5*u^2
	base = lbm_pkg::FX_ONE - lbm_pkg::fx_x1_5(usq);
	w9   = lbm_pkg::fx_mul(rho, lbm_pkg::FX_ONE_9TH);
	w36  = lbm_pkg::fx_mul(rho, lbm_pkg::FX_ONE_36TH);
	cx   = lbm_pkg::fx_x3(res.ux);
	cy   = lbm_pkg::fx_x3(res.uy);
	dp   = lbm_pkg::fx_x4_5(usq + uxuy + uxuy);
	dm   = lbm_pkg::fx_x4_5(usq - uxuy - uxuy);

	res.pop.nn  = bgk_relax(p.nn, w9, base + cy + lbm_pkg::fx_x4_5(uy2), omega);
	res.pop.ns  = bgk_relax(p.ns, w9, base - cy + lbm_pkg::fx_x4_5(uy2), omega);
	res.pop.ne  = bgk_relax(p.ne, w9, base + cx + lbm_pkg::fx_x4_5(ux2), omega);
	res.pop.nw  = bgk_relax(p.nw, w9, base - cx + lbm_pkg::fx_x4_5(ux2), omega);
	res.pop.nne = bgk_relax(p.nne, w36, base + cy + cx + dp, omega);
	res.pop.nnw = bgk_relax(p.nnw, w36, base + cy - cx + dm, omega);
	res.pop.nse = bgk_relax(p.nse, w36, base - cy + cx + dm, omega);
	res.pop.nsw = bgk_relax(p.nsw, w36, base - cy - cx + dp, omega);

	// Rest population closes the mass balance
	res.pop.n0 = rho - (res.pop.nn + res.pop.ns + res.pop.ne + res.pop.nw
		+ res.pop.nne + res.pop.nnw + res.pop.nse + res.pop.nsw);
	return res;
endfunction

`endif

// File: verif/lbm_collide_tb.sv
`timescale 1ns/1ps

module lbm_collide_tb;

	`include "lbm_ref.svh"

	typedef struct {
		site_result_t    exp;
		lbm_pkg::pop_t   in_pop;
		lbm_pkg::fixed_t in_rho;
		bit              zero_omega;
		int              due_edge;
	} pending_t;

	logic            CLOCK_50;
	logic            rst_n;
	logic            in_valid;
	lbm_pkg::fixed_t omega;
	lbm_pkg::pop_t   pop_drv;
	lbm_pkg::pop_t   pop_seen;
	lbm_pkg::fixed_t n0_out;
	lbm_pkg::fixed_t nn_out;
	lbm_pkg::fixed_t ns_out;
	lbm_pkg::fixed_t ne_out;
	lbm_pkg::fixed_t nw_out;
	lbm_pkg::fixed_t nne_out;
	lbm_pkg::fixed_t nnw_out;
	lbm_pkg::fixed_t nse_out;
	lbm_pkg::fixed_t nsw_out;
	lbm_pkg::fixed_t ux_seen;
	lbm_pkg::fixed_t uy_seen;
	logic            out_valid;

	pending_t    expect_q [$];
	int          edges = 0;
	logic [31:0] rng_state = 32'hbfe6;
	string       pop_fields [9] = '{"n0", "nn", "ns", "ne", "nw", "nne", "nnw", "nse", "nsw"};

	lbm_collide dut_i (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.omega    (omega),
		.n0_in    (pop_drv.n0),
		.nn_in    (pop_drv.nn),
		.ns_in    (pop_drv.ns),
		.ne_in    (pop_drv.ne),
		.nw_in    (pop_drv.nw),
		.nne_in   (pop_drv.nne),
		.nnw_in   (pop_drv.nnw),
		.nse_in   (pop_drv.nse),
		.nsw_in   (pop_drv.nsw),
		.n0_out   (n0_out),
		.nn_out   (nn_out),
		.ns_out   (ns_out),
		.ne_out   (ne_out),
		.nw_out   (nw_out),
		.nne_out  (nne_out),
		.nnw_out  (nnw_out),
		.nse_out  (nse_out),
		.nsw_out  (nsw_out),
		.ux       (ux_seen),
		.uy       (uy_seen),
		.out_valid(out_valid)
	);

	assign pop_seen = '{n0: n0_out, nn: nn_out, ns: ns_out, ne: ne_out, nw: nw_out,
		nne: nne_out, nnw: nnw_out, nse: nse_out, nsw: nsw_out};

	initial begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	always @(posedge CLOCK_50) edges <= edges + 1;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic stop_with_failure(string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_fixed(string name, lbm_pkg::fixed_t exp_val, lbm_pkg::fixed_t act_val);
		if (act_val !== exp_val) begin
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp_val, act_val);
			stop_with_failure("value mismatch on a fixed-point output");
		end
	endtask

	task automatic check_pop(string name, lbm_pkg::pop_t exp_pop, lbm_pkg::pop_t act_pop);
		lbm_pkg::fixed_t e;
		lbm_pkg::fixed_t a;
		for (int i = 0; i < 9; i++) begin
			// n0 sits in the top word
			e = exp_pop[(8 - i) * 27 +: 27];
			a = act_pop[(8 - i) * 27 +: 27];
			if (a !== e) begin
				$display("[ERROR] %0t %s.%s expected %0d actual %0d", $time, name,
					pop_fields[i], e, a);
				stop_with_failure("value mismatch on a population output");
			end
		end
	endtask

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// Weight plus an offset of about +/-0.002
	function automatic lbm_pkg::fixed_t near(lbm_pkg::fixed_t w, logic [31:0] r);
		return w + lbm_pkg::fixed_t'(r[16:0]) - 27'sd65536;
	endfunction

	task automatic random_site(output lbm_pkg::pop_t p, output lbm_pkg::fixed_t om);
		logic [31:0] r [10];
		for (int i = 0; i < 10; i++) begin
			next_rand(r[i]);
		end
		p.n0  = near(lbm_pkg::FX_ONE_9TH <<< 2, r[0]);
		p.nn  = near(lbm_pkg::FX_ONE_9TH, r[1]);
		p.ns  = near(lbm_pkg::FX_ONE_9TH, r[2]);
		p.ne  = near(lbm_pkg::FX_ONE_9TH, r[3]);
		p.nw  = near(lbm_pkg::FX_ONE_9TH, r[4]);
		p.nne = near(lbm_pkg::FX_ONE_36TH, r[5]);
		p.nnw = near(lbm_pkg::FX_ONE_36TH, r[6]);
		p.nse = near(lbm_pkg::FX_ONE_36TH, r[7]);
		p.nsw = near(lbm_pkg::FX_ONE_36TH, r[8]);
		// 0 up to just under 2.0
		om = lbm_pkg::fixed_t'(r[9][25:0]);
	endtask

	// Called right after a falling edge
	task automatic drive_site(lbm_pkg::pop_t p, lbm_pkg::fixed_t om, bit zero_flag);
		pending_t entry;
		entry.exp        = lbm_ref_collide(p, om);
		entry.in_pop     = p;
		entry.in_rho     = p.n0 + p.nn + p.ns + p.ne + p.nw + p.nne + p.nnw + p.nse + p.nsw;
		entry.zero_omega = zero_flag;
		// Third rising edge from the one that samples the site
		entry.due_edge   = edges + 3;
		expect_q.push_back(entry);
		pop_drv  = p;
		omega    = om;
		in_valid = 1'b1;
		@(negedge CLOCK_50);
	endtask

	task automatic idle_cycle();
		in_valid = 1'b0;
		@(negedge CLOCK_50);
	endtask

	//////////////////////////////
	// Scoreboard
	//////////////////////////////

	always @(negedge CLOCK_50) begin
		pending_t        head;
		lbm_pkg::fixed_t mass;
		if (out_valid === 1'b1) begin
			if (expect_q.size() == 0) begin
				stop_with_failure("out_valid pulsed with no site in flight");
			end else if (expect_q[0].due_edge != edges) begin
				stop_with_failure("out_valid pulsed on the wrong cycle for the oldest site");
			end else begin
				head = expect_q.pop_front();
				mass = pop_seen.n0 + pop_seen.nn + pop_seen.ns + pop_seen.ne + pop_seen.nw
					+ pop_seen.nne + pop_seen.nnw + pop_seen.nse + pop_seen.nsw;
				check_fixed("mass_sum", head.in_rho, mass);
				if (head.zero_omega) begin
					check_pop("pop_out_vs_in", head.in_pop, pop_seen);
				end
				check_pop("pop_out", head.exp.pop, pop_seen);
				check_fixed("ux", head.exp.ux, ux_seen);
				check_fixed("uy", head.exp.uy, uy_seen);
			end
		end else if (out_valid !== 1'b0) begin
			stop_with_failure("out_valid is unknown");
		end else if (expect_q.size() != 0 && expect_q[0].due_edge <= edges) begin
			stop_with_failure("out_valid missing when the oldest site was due");
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		lbm_pkg::pop_t   p;
		lbm_pkg::fixed_t om;
		logic [31:0]     r;
		int              wait_cycles;

		rst_n    = 1'b0;
		in_valid = 1'b0;
		omega    = '0;
		pop_drv  = '0;
		@(negedge CLOCK_50);
		// Strobes during reset must not start a site
		in_valid = 1'b1;
		repeat (4) @(negedge CLOCK_50);
		in_valid = 1'b0;
		rst_n    = 1'b1;
		repeat (3) idle_cycle();

		// Random sites with random gaps
		for (int s = 0; s < 60; s++) begin
			random_site(p, om);
			drive_site(p, om, 1'b0);
			next_rand(r);
			repeat (r[1:0]) idle_cycle();
		end

		// Back to back for 200 cycles
		for (int s = 0; s < 200; s++) begin
			random_site(p, om);
			drive_site(p, om, 1'b0);
		end

		// Omega zero leaves every population as it came in
		for (int s = 0; s < 20; s++) begin
			random_site(p, om);
			drive_site(p, 27'sd0, 1'b1);
		end
		idle_cycle();

		wait_cycles = 0;
		while (expect_q.size() != 0 && wait_cycles <= 20) begin
			@(negedge CLOCK_50);
			wait_cycles++;
		end

		if (expect_q.size() != 0) begin
			stop_with_failure("timed out waiting for the pipeline to drain");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

// File: rtl/lbm_collide.sv
`timescale 1ns/1ps

module lbm_collide (
	input  logic            CLOCK_50,
	input  logic            rst_n,
	input  logic            in_valid,
	input  lbm_pkg::fixed_t omega,
	input  lbm_pkg::fixed_t n0_in,
	input  lbm_pkg::fixed_t nn_in,
	input  lbm_pkg::fixed_t ns_in,
	input  lbm_pkg::fixed_t ne_in,
	input  lbm_pkg::fixed_t nw_in,
	input  lbm_pkg::fixed_t nne_in,
	input  lbm_pkg::fixed_t nnw_in,
	input  lbm_pkg::fixed_t nse_in,
	input  lbm_pkg::fixed_t nsw_in,
	output lbm_pkg::fixed_t n0_out,
	output lbm_pkg::fixed_t nn_out,
	output lbm_pkg::fixed_t ns_out,
	output lbm_pkg::fixed_t ne_out,
	output lbm_pkg::fixed_t nw_out,
	output lbm_pkg::fixed_t nne_out,
	output lbm_pkg::fixed_t nnw_out,
	output lbm_pkg::fixed_t nse_out,
	output lbm_pkg::fixed_t nsw_out,
	output lbm_pkg::fixed_t ux,
	output lbm_pkg::fixed_t uy,
	output logic            out_valid
);

	lbm_pkg::pop_t pop_in;
	lbm_pkg::pop_t pop_out;

	assign pop_in = '{n0: n0_in, nn: nn_in, ns: ns_in, ne: ne_in, nw: nw_in,
		nne: nne_in, nnw: nnw_in, nse: nse_in, nsw: nsw_in};

	assign n0_out  = pop_out.n0;
	assign nn_out  = pop_out.nn;
	assign ns_out  = pop_out.ns;
	assign ne_out  = pop_out.ne;
	assign nw_out  = pop_out.nw;
	assign nne_out = pop_out.nne;
	assign nnw_out = pop_out.nnw;
	assign nse_out = pop_out.nse;
	assign nsw_out = pop_out.nsw;

	//////////////////////////////
	// Pipeline
	//////////////////////////////

	moment_if mo_if ();
	relax_if  ax_if ();
	relax_if  dg_if ();

	lbm_moments u_moments (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.pop_in   (pop_in),
		.omega    (omega),
		.mo       (mo_if)
	);

	// Axis and diagonal stages run side by side
	lbm_axis_relax u_axis_relax (.CLOCK_50(CLOCK_50), .rst_n(rst_n), .mo(mo_if), .ax(ax_if));

	lbm_diag_relax u_diag_relax (.CLOCK_50(CLOCK_50), .rst_n(rst_n), .mo(mo_if), .dg(dg_if));

	lbm_rest_combine u_rest_combine (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.mo        (mo_if),
		.ax        (ax_if),
		.dg        (dg_if),
		.pop_out   (pop_out),
		.ux        (ux),
		.uy        (uy),
		.out_valid (out_valid)
	);

endmodule

// File: rtl/lbm_rest_combine.sv
`timescale 1ns/1ps

module lbm_rest_combine (
	input  logic            CLOCK_50,
	input  logic            rst_n,
	moment_if.rest          mo,
	relax_if.dst            ax,
	relax_if.dst            dg,
	output lbm_pkg::pop_t   pop_out,
	output lbm_pkg::fixed_t ux,
	output lbm_pkg::fixed_t uy,
	output logic            out_valid
);

	// Moments held one stage to line up with the relaxers
	lbm_pkg::fixed_t rho_d;
	lbm_pkg::fixed_t ux_d;
	lbm_pkg::fixed_t uy_d;
	lbm_pkg::fixed_t moving_sum;

	always_ff @(posedge CLOCK_50) begin
		if (mo.valid) begin
			rho_d <= mo.rho;
			ux_d  <= mo.ux;
			uy_d  <= mo.uy;
		end
	end

	// Rest population takes whatever mass is left, so the sum is exact
	assign moving_sum = ax.p0 + ax.p1 + ax.p2 + ax.p3 + dg.p0 + dg.p1 + dg.p2 + dg.p3;

	//////////////////////////////
	// Stage 3 registers
	//////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= ax.valid & dg.valid;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (ax.valid) begin
			pop_out.n0  <= rho_d - moving_sum;
			pop_out.nn  <= ax.p0;
			pop_out.ns  <= ax.p1;
			pop_out.ne  <= ax.p2;
			pop_out.nw  <= ax.p3;
			pop_out.nne <= dg.p0;
			pop_out.nnw <= dg.p1;
			pop_out.nse <= dg.p2;
			pop_out.nsw <= dg.p3;
			ux          <= ux_d;
			uy          <= uy_d;
		end
	end

	// Relaxed populations and held moments must be known when a site arrives
	a_relaxed_known: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		ax.valid |-> !$isunknown({ax.p0, ax.p1, ax.p2, ax.p3, dg.p0, dg.p1, dg.p2, dg.p3,
			rho_d, ux_d, uy_d})
	);

endmodule

// File: rtl/lbm_diag_relax.sv
`timescale 1ns/1ps

module lbm_diag_relax (
	input  logic  CLOCK_50,
	input  logic  rst_n,
	moment_if.diag mo,
	relax_if.src   dg
);

	// Index order nne, nnw, nse, nsw
	lbm_pkg::fixed_t n_cur   [4];
	lbm_pkg::fixed_t bracket [4];
	lbm_pkg::fixed_t eq      [4];
	lbm_pkg::fixed_t relaxed [4];

	// 4.5*(ux +/- uy)^2 built from u2 and 2*ux*uy
	lbm_pkg::fixed_t sq45_p;
	lbm_pkg::fixed_t sq45_m;

	assign sq45_p = lbm_pkg::fx_x4_5(mo.u2 + mo.uxuy2);
	assign sq45_m = lbm_pkg::fx_x4_5(mo.u2 - mo.uxuy2);

	always_comb begin
		n_cur[0] = mo.pop.nne;
		n_cur[1] = mo.pop.nnw;
		n_cur[2] = mo.pop.nse;
		n_cur[3] = mo.pop.nsw;

		// Signs follow each diagonal's x and y direction
		bracket[0] = lbm_pkg::FX_ONE + mo.uy3 + mo.ux3 + sq45_p - mo.u2_15;
		bracket[1] = lbm_pkg::FX_ONE + mo.uy3 - mo.ux3 + sq45_m - mo.u2_15;
		bracket[2] = lbm_pkg::FX_ONE - mo.uy3 + mo.ux3 + sq45_m - mo.u2_15;
		bracket[3] = lbm_pkg::FX_ONE - mo.uy3 - mo.ux3 + sq45_p - mo.u2_15;

		for (int i = 0; i < 4; i++) begin
			eq[i]      = lbm_pkg::fx_mul(mo.w36_rho, bracket[i]);
			relaxed[i] = n_cur[i] + lbm_pkg::fx_mul(mo.omega, eq[i] - n_cur[i]);
		end
	end

	//////////////////////////////
	// Stage 2 registers
	//////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			dg.valid <= 1'b0;
		end else begin
			dg.valid <= mo.valid;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (mo.valid) begin
			dg.p0 <= relaxed[0];
			dg.p1 <= relaxed[1];
			dg.p2 <= relaxed[2];
			dg.p3 <= relaxed[3];
		end
	end

endmodule

// File: rtl/lbm_axis_relax.sv
`timescale 1ns/1ps

module lbm_axis_relax (
	input  logic  CLOCK_50,
	input  logic  rst_n,
	moment_if.axis mo,
	relax_if.src   ax
);

	// Index order nn, ns, ne, nw
	lbm_pkg::fixed_t n_cur   [4];
	lbm_pkg::fixed_t bracket [4];
	lbm_pkg::fixed_t eq      [4];
	lbm_pkg::fixed_t relaxed [4];

	always_comb begin
		n_cur[0] = mo.pop.nn;
		n_cur[1] = mo.pop.ns;
		n_cur[2] = mo.pop.ne;
		n_cur[3] = mo.pop.nw;

		bracket[0] = lbm_pkg::FX_ONE + mo.uy3 + mo.uy2_45 - mo.u2_15;
		bracket[1] = lbm_pkg::FX_ONE - mo.uy3 + mo.uy2_45 - mo.u2_15;
		bracket[2] = lbm_pkg::FX_ONE + mo.ux3 + mo.ux2_45 - mo.u2_15;
		bracket[3] = lbm_pkg::FX_ONE - mo.ux3 + mo.ux2_45 - mo.u2_15;

		// BGK step, n + omega*(eq - n)
		for (int i = 0; i < 4; i++) begin
			eq[i]      = lbm_pkg::fx_mul(mo.w9_rho, bracket[i]);
			relaxed[i] = n_cur[i] + lbm_pkg::fx_mul(mo.omega, eq[i] - n_cur[i]);
		end
	end

	//////////////////////////////
	// Stage 2 registers
	//////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			ax.valid <= 1'b0;
		end else begin
			ax.valid <= mo.valid;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (mo.valid) begin
			ax.p0 <= relaxed[0];
			ax.p1 <= relaxed[1];
			ax.p2 <= relaxed[2];
			ax.p3 <= relaxed[3];
		end
	end

	// Moment terms of a presented site must be known
	a_moments_known: assert property (
		@(posedge CLOCK_50) disable iff (!rst_n)
		mo.valid |-> !$isunknown({mo.pop, mo.w9_rho, mo.ux3, mo.uy3, mo.ux2_45, mo.uy2_45,
			mo.u2_15, mo.omega})
	);

endmodule

// File: rtl/lbm_moments.sv
`timescale 1ns/1ps

module lbm_moments (
	input  logic            CLOCK_50,
	input  logic            rst_n,
	input  logic            in_valid,
	input  lbm_pkg::pop_t   pop_in,
	input  lbm_pkg::fixed_t omega,
	moment_if.src           mo
);

	lbm_pkg::fixed_t rho;
	lbm_pkg::fixed_t rho_m1;
	lbm_pkg::fixed_t rho_inv;
	lbm_pkg::fixed_t mom_x;
	lbm_pkg::fixed_t mom_y;
	lbm_pkg::fixed_t ux;
	lbm_pkg::fixed_t uy;
	lbm_pkg::fixed_t ux2;
	lbm_pkg::fixed_t uy2;
	lbm_pkg::fixed_t uxuy;
	lbm_pkg::fixed_t u2;

	//////////////////////////////
	// Density and velocity
	//////////////////////////////

	assign rho = pop_in.n0 + pop_in.nn + pop_in.ns + pop_in.nw + pop_in.ne
		+ pop_in.nnw + pop_in.nne + pop_in.nsw + pop_in.nse;

	// 1/rho ~ 1 - (rho-1) + (rho-1)^2, good near rho = 1
	assign rho_m1  = rho - lbm_pkg::FX_ONE;
	assign rho_inv = lbm_pkg::FX_ONE - rho_m1 + lbm_pkg::fx_mul(rho_m1, rho_m1);

	// East minus west, north minus south
	assign mom_x = pop_in.ne + pop_in.nne + pop_in.nse - pop_in.nw - pop_in.nnw - pop_in.nsw;
	assign mom_y = pop_in.nn + pop_in.nne + pop_in.nnw - pop_in.ns - pop_in.nse - pop_in.nsw;

	assign ux = lbm_pkg::fx_mul(rho_inv, mom_x);
	assign uy = lbm_pkg::fx_mul(rho_inv, mom_y);

	assign ux2  = lbm_pkg::fx_mul(ux, ux);
	assign uy2  = lbm_pkg::fx_mul(uy, uy);
	assign uxuy = lbm_pkg::fx_mul(ux, uy);
	assign u2   = ux2 + uy2;

	//////////////////////////////
	// Stage 1 registers
	//////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			mo.valid <= 1'b0;
		end else begin
			mo.valid <= in_valid;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (in_valid) begin
			mo.pop     <= pop_in;
			mo.rho     <= rho;
			mo.ux      <= ux;
			mo.uy      <= uy;
			mo.w9_rho  <= lbm_pkg::fx_mul(rho, lbm_pkg::FX_ONE_9TH);
			mo.w36_rho <= lbm_pkg::fx_mul(rho, lbm_pkg::FX_ONE_36TH);
			mo.ux3     <= lbm_pkg::fx_x3(ux);
			mo.uy3     <= lbm_pkg::fx_x3(uy);
			mo.ux2_45  <= lbm_pkg::fx_x4_5(ux2);
			mo.uy2_45  <= lbm_pkg::fx_x4_5(uy2);
			mo.u2_15   <= lbm_pkg::fx_x1_5(u2);
			mo.u2      <= u2;
			mo.uxuy2   <= uxuy <<< 1;
			mo.omega   <= omega;
		end
	end

endmodule

// File: rtl/relax_if.sv
`timescale 1ns/1ps

interface relax_if;

	logic            valid;
	// Four relaxed populations, order fixed per instance
	lbm_pkg::fixed_t p0;
	lbm_pkg::fixed_t p1;
	lbm_pkg::fixed_t p2;
	lbm_pkg::fixed_t p3;

	modport src (output valid, p0, p1, p2, p3);

	modport dst (input valid, p0, p1, p2, p3);

endinterface

// File: rtl/moment_if.sv
`timescale 1ns/1ps

interface moment_if;

	logic            valid;
	lbm_pkg::pop_t   pop;
	lbm_pkg::fixed_t rho;
	lbm_pkg::fixed_t ux;
	lbm_pkg::fixed_t uy;
	// Weighted densities
	lbm_pkg::fixed_t w9_rho;
	lbm_pkg::fixed_t w36_rho;
	// Equilibrium terms shared by all directions
	lbm_pkg::fixed_t ux3;
	lbm_pkg::fixed_t uy3;
	lbm_pkg::fixed_t ux2_45;
	lbm_pkg::fixed_t uy2_45;
	lbm_pkg::fixed_t u2_15;
	lbm_pkg::fixed_t u2;
	lbm_pkg::fixed_t uxuy2;
	lbm_pkg::fixed_t omega;

	modport src (output valid, pop, rho, ux, uy, w9_rho, w36_rho, ux3, uy3,
		ux2_45, uy2_45, u2_15, u2, uxuy2, omega);

	modport axis (input valid, pop, w9_rho, ux3, uy3, ux2_45, uy2_45, u2_15, omega);

	modport diag (input valid, pop, w36_rho, ux3, uy3, u2_15, u2, uxuy2, omega);

	modport rest (input valid, rho, ux, uy);

endinterface

// File: rtl/lbm_pkg.sv
package lbm_pkg;

	//////////////////////////////
	// Fixed-point format
	//////////////////////////////

	// Signed 2.25, 1.0 is 2^25
	typedef logic signed [26:0] fixed_t;

	localparam int FRAC_BITS = 25;

	localparam fixed_t FX_ONE = fixed_t'(1 << FRAC_BITS);

	// D2Q9 lattice weights
	localparam fixed_t FX_ONE_9TH  = 27'sd3728270;
	localparam fixed_t FX_ONE_36TH = 27'sd932067;

	// One lattice site, rest population first
	typedef struct packed {
		fixed_t n0;
		fixed_t nn;
		fixed_t ns;
		fixed_t ne;
		fixed_t nw;
		fixed_t nne;
		fixed_t nnw;
		fixed_t nse;
		fixed_t nsw;
	} pop_t;

	//////////////////////////////
	// Arithmetic helpers
	//////////////////////////////

	// 2.25 product from the full 54-bit result.
	// Only 27 bits survive the cast, so the value is p[51:25]
	function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
		logic signed [53:0] p;
		p = a * b;
		return fixed_t'({p[53], p[51:FRAC_BITS]});
	endfunction

	// Times 3
	function automatic fixed_t fx_x3(fixed_t a);
		return a + (a <<< 1);
	endfunction

	// Times 4.5
	function automatic fixed_t fx_x4_5(fixed_t a);
		return (a <<< 2) + (a >>> 1);
	endfunction

	// Times 1.5
	function automatic fixed_t fx_x1_5(fixed_t a);
		return a + (a >>> 1);
	endfunction

endpackage
